//--- cpu.f
rtl/cpuPkg.sv
rtl/instructionDecoder.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/controlUnit.sv
rtl/programCounter.sv
rtl/cpu.sv
tests/cpu_assertions.sv
tests/cpuTb.sv

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic        Clock,
    input  logic        rstN,
    input  logic [31:0] operand1,
    input  logic [31:0] operand2,
    input  logic [5:0]  aluFunction,
    input  logic        start,
    output logic        done,
    output logic [31:0] result
);

    logic [cpuPkg::dataWidth-1:0] quickResult;
    logic [cpuPkg::dataWidth-1:0] multiplicand;
    logic [cpuPkg::dataWidth-1:0] multiplier;
    logic [cpuPkg::dataWidth-1:0] product;
    logic [cpuPkg::dataWidth-1:0] partialSum;
    logic [4:0] stepCount;
    logic busy;
    logic lastStep;

    always_comb begin
        case (aluFunction)
            cpuPkg::fnAdd: quickResult = operand1 + operand2;
            cpuPkg::fnSub: quickResult = operand1 - operand2;
            cpuPkg::fnAnd: quickResult = operand1 & operand2;
            cpuPkg::fnOr:  quickResult = operand1 | operand2;
            cpuPkg::fnXor: quickResult = operand1 ^ operand2;
            cpuPkg::fnShl: quickResult = operand1 << operand2[4:0];
            cpuPkg::fnShr: quickResult = operand1 >> operand2[4:0];
            default:       quickResult = '0;
        endcase
    end

    // One shift-add step per cycle keeping the low 32 bits
    assign partialSum = product + (multiplier[0] ? multiplicand : '0);
    assign lastStep = busy && (stepCount == 5'd31);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            busy <= 1'b0;
            done <= 1'b0;
            stepCount <= '0;
        end else begin
            done <= lastStep;
            if (start) begin
                busy <= aluFunction == cpuPkg::fnMul;
                done <= aluFunction != cpuPkg::fnMul;
                stepCount <= '0;
            end else if (busy) begin
                stepCount <= stepCount + 5'd1;
                if (lastStep) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (start) begin
            multiplicand <= operand1;
            multiplier <= operand2;
            product <= '0;
            if (aluFunction != cpuPkg::fnMul) begin
                result <= quickResult;
            end
        end else if (busy) begin
            product <= partialSum;
            multiplicand <= multiplicand << 1;
            multiplier <= multiplier >> 1;
            if (lastStep) begin
                result <= partialSum;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic        Clock,
    input  logic        rstN,
    input  logic        instructionLoaded,
    input  logic        dataLoaded,
    input  logic        dataStored,
    input  logic        aluDone,
    input  logic [31:0] sourceData1,
    input  logic        isLoad,
    input  logic        isStore,
    input  logic        isJal,
    input  logic        isJr,
    input  logic        isBranch,
    input  logic        branchOnZero,
    input  logic        isHalt,
    output logic        readInstruction,
    output logic        decodeStrobe,
    output logic        aluStart,
    output logic        readData,
    output logic        writeData,
    output logic        regWrite,
    output logic        pcStep,
    output logic        pcJump,
    output logic        halted
);

    logic [2:0] state;
    logic [2:0] nextState;
    logic startPending;
    logic branchTaken;
    logic needsWriteBack;
    logic takeJump;

    // Branch condition on source 1
    assign branchTaken = isBranch && ((sourceData1 == '0) == branchOnZero);
    assign needsWriteBack = !isStore && !isJr && !isBranch;
    assign takeJump = isJal || isJr || branchTaken;

    always_comb begin
        nextState = state;
        case (state)
            cpuPkg::stFetch: begin
                if (instructionLoaded) begin
                    nextState = cpuPkg::stDecode;
                end
            end
            cpuPkg::stDecode: nextState = cpuPkg::stExecute;
            cpuPkg::stExecute: begin
                if (isHalt) begin
                    nextState = cpuPkg::stHalt;
                end else if (aluDone) begin
                    if (isLoad || isStore) begin
                        nextState = cpuPkg::stMemory;
                    end else if (needsWriteBack) begin
                        nextState = cpuPkg::stWriteBack;
                    end else begin
                        nextState = cpuPkg::stPcUpdate;
                    end
                end
            end
            cpuPkg::stMemory: begin
                if ((isLoad && dataLoaded) || (isStore && dataStored)) begin
                    nextState = cpuPkg::stPcUpdate;
                end
            end
            cpuPkg::stWriteBack: nextState = cpuPkg::stPcUpdate;
            cpuPkg::stPcUpdate: nextState = cpuPkg::stFetch;
            cpuPkg::stHalt: nextState = cpuPkg::stHalt;
            default: nextState = cpuPkg::stFetch;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state <= cpuPkg::stFetch;
            startPending <= 1'b0;
        end else begin
            state <= nextState;
            // Decoder outputs settle one cycle after the strobe
            startPending <= state == cpuPkg::stDecode;
        end
    end

    assign readInstruction = state == cpuPkg::stFetch;
    assign decodeStrobe = state == cpuPkg::stDecode;
    assign aluStart = startPending && !isHalt;
    assign readData = (state == cpuPkg::stMemory) && isLoad;
    assign writeData = (state == cpuPkg::stMemory) && isStore;
    // Load data is only valid alongside dataLoaded, so it is written right then
    assign regWrite = (state == cpuPkg::stWriteBack)
        || ((state == cpuPkg::stMemory) && isLoad && dataLoaded);
    assign pcJump = (state == cpuPkg::stPcUpdate) && takeJump;
    assign pcStep = (state == cpuPkg::stPcUpdate) && !takeJump;
    assign halted = state == cpuPkg::stHalt;

endmodule

`default_nettype wire

//--- rtl/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  logic        Clock,
    input  logic        rstN,
    input  logic [31:0] instruction,
    input  logic        instructionLoaded,
    input  logic [31:0] dataIn,
    input  logic        dataLoaded,
    input  logic        dataStored,
    output logic [31:0] instructionAddress,
    output logic        readInstruction,
    output logic [31:0] dataAddress,
    output logic [31:0] dataOut,
    output logic        readData,
    output logic        writeData,
    output logic        halted
);

    localparam int padWidth = cpuPkg::dataWidth - cpuPkg::pcWidth;

    // Decoder outputs
    logic [5:0] sourceReg1;
    logic [5:0] sourceReg2;
    logic [5:0] destReg;
    logic [31:0] immediate;
    logic [25:0] jumpTarget;
    logic [5:0] aluFunction;
    logic useImmediate;
    logic isLoad;
    logic isStore;
    logic isJal;
    logic isJr;
    logic isBranch;
    logic branchOnZero;
    logic isRelative;
    logic isHalt;

    logic [31:0] sourceData1;
    logic [31:0] sourceData2;
    logic [31:0] aluOperand1;
    logic [31:0] aluOperand2;
    logic [31:0] aluResult;
    logic [31:0] writeBackData;
    logic aluDone;
    logic decodeStrobe;
    logic aluStart;
    logic regWrite;
    logic pcStep;
    logic pcJump;
    logic [25:0] currentPc;
    logic [25:0] nextPc;
    logic [25:0] linkPc;

    assign linkPc = currentPc + 26'd1;

    // Branches add the offset to the PC
    assign aluOperand1 = isRelative ? {{padWidth{1'b0}}, currentPc} : sourceData1;
    assign aluOperand2 = useImmediate ? immediate : sourceData2;

    always_comb begin
        if (isJal) begin
            writeBackData = {{padWidth{1'b0}}, linkPc};
        end else if (isLoad) begin
            writeBackData = dataIn;
        end else begin
            writeBackData = aluResult;
        end
    end

    always_comb begin
        if (isJr) begin
            nextPc = sourceData1[cpuPkg::pcWidth-1:0];
        end else if (isJal) begin
            nextPc = jumpTarget;
        end else begin
            nextPc = aluResult[cpuPkg::pcWidth-1:0];
        end
    end

    assign instructionAddress = {{padWidth{1'b0}}, currentPc};
    assign dataAddress = aluResult;
    assign dataOut = sourceData2;

    instructionDecoder decoder (
        .Clock(Clock), .rstN(rstN), .instruction(instruction), .decodeStrobe(decodeStrobe),
        .sourceReg1(sourceReg1), .sourceReg2(sourceReg2), .destReg(destReg),
        .immediate(immediate), .jumpTarget(jumpTarget), .aluFunction(aluFunction),
        .useImmediate(useImmediate), .isLoad(isLoad), .isStore(isStore), .isJal(isJal),
        .isJr(isJr), .isBranch(isBranch), .branchOnZero(branchOnZero),
        .isRelative(isRelative), .isHalt(isHalt)
    );

    registerFile registers (
        .Clock(Clock), .rstN(rstN), .sourceReg1(sourceReg1), .sourceReg2(sourceReg2),
        .destReg(destReg), .writeData(writeBackData), .writeEnable(regWrite),
        .sourceData1(sourceData1), .sourceData2(sourceData2)
    );

    alu arithmetic (
        .Clock(Clock), .rstN(rstN), .operand1(aluOperand1), .operand2(aluOperand2),
        .aluFunction(aluFunction), .start(aluStart), .done(aluDone), .result(aluResult)
    );

    controlUnit control (
        .Clock(Clock), .rstN(rstN), .instructionLoaded(instructionLoaded),
        .dataLoaded(dataLoaded), .dataStored(dataStored), .aluDone(aluDone),
        .sourceData1(sourceData1), .isLoad(isLoad), .isStore(isStore), .isJal(isJal),
        .isJr(isJr), .isBranch(isBranch), .branchOnZero(branchOnZero), .isHalt(isHalt),
        .readInstruction(readInstruction), .decodeStrobe(decodeStrobe), .aluStart(aluStart),
        .readData(readData), .writeData(writeData), .regWrite(regWrite),
        .pcStep(pcStep), .pcJump(pcJump), .halted(halted)
    );

    programCounter pc (
        .Clock(Clock), .rstN(rstN), .nextPc(nextPc), .step(pcStep), .jump(pcJump),
        .currentPc(currentPc)
    );

endmodule

`default_nettype wire

//--- rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regIndexWidth = 6;
    localparam int pcWidth = 26;
    localparam int immWidth = 14;

    // Major opcodes in the top six bits of every word
    localparam logic [5:0] opAluReg = 6'h00;
    localparam logic [5:0] opAluImm = 6'h01;
    localparam logic [5:0] opLoad = 6'h02;
    localparam logic [5:0] opStore = 6'h03;
    localparam logic [5:0] opJal = 6'h04;
    localparam logic [5:0] opJr = 6'h05;
    localparam logic [5:0] opBrz = 6'h06;
    localparam logic [5:0] opBrnz = 6'h07;
    localparam logic [5:0] opHalt = 6'h3f;

    // ALU functions from the funct field of register-form words
    localparam logic [5:0] fnAdd = 6'h00;
    localparam logic [5:0] fnSub = 6'h01;
    localparam logic [5:0] fnAnd = 6'h02;
    localparam logic [5:0] fnOr = 6'h03;
    localparam logic [5:0] fnXor = 6'h04;
    localparam logic [5:0] fnShl = 6'h05;
    localparam logic [5:0] fnShr = 6'h06;
    localparam logic [5:0] fnMul = 6'h07;

    // Control FSM states
    localparam logic [2:0] stFetch = 3'd0;
    localparam logic [2:0] stDecode = 3'd1;
    localparam logic [2:0] stExecute = 3'd2;
    localparam logic [2:0] stMemory = 3'd3;
    localparam logic [2:0] stWriteBack = 3'd4;
    localparam logic [2:0] stPcUpdate = 3'd5;
    localparam logic [2:0] stHalt = 3'd6;

    // Register form, immediate form and jump form share one word
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [regIndexWidth-1:0] rd;
            logic [regIndexWidth-1:0] rs1;
            logic [regIndexWidth-1:0] rs2;
            logic [5:0] funct;
            logic [1:0] unused;
        } rForm;
        struct packed {
            logic [5:0] opcode;
            logic [regIndexWidth-1:0] rd;
            logic [regIndexWidth-1:0] rs1;
            logic signed [immWidth-1:0] imm;
        } iForm;
        struct packed {
            logic [5:0] opcode;
            logic [pcWidth-1:0] target;
        } jForm;
    } instructionWord;

endpackage

`default_nettype wire

//--- rtl/instructionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder (
    input  logic        Clock,
    input  logic        rstN,
    input  logic [31:0] instruction,
    input  logic        decodeStrobe,
    output logic [5:0]  sourceReg1,
    output logic [5:0]  sourceReg2,
    output logic [5:0]  destReg,
    output logic [31:0] immediate,
    output logic [25:0] jumpTarget,
    output logic [5:0]  aluFunction,
    output logic        useImmediate,
    output logic        isLoad,
    output logic        isStore,
    output logic        isJal,
    output logic        isJr,
    output logic        isBranch,
    output logic        branchOnZero,
    output logic        isRelative,
    output logic        isHalt
);

    cpuPkg::instructionWord word;
    logic [5:0] opcode;
    logic branchOp;

    assign word = instruction;
    assign opcode = word.rForm.opcode;
    assign branchOp = (opcode == cpuPkg::opBrz) || (opcode == cpuPkg::opBrnz);

    // Class flags
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            useImmediate <= 1'b0;
            isLoad <= 1'b0;
            isStore <= 1'b0;
            isJal <= 1'b0;
            isJr <= 1'b0;
            isBranch <= 1'b0;
            branchOnZero <= 1'b0;
            isRelative <= 1'b0;
            isHalt <= 1'b0;
        end else if (decodeStrobe) begin
            useImmediate <= (opcode == cpuPkg::opAluImm) || (opcode == cpuPkg::opLoad)
                || (opcode == cpuPkg::opStore) || branchOp;
            isLoad <= opcode == cpuPkg::opLoad;
            isStore <= opcode == cpuPkg::opStore;
            isJal <= opcode == cpuPkg::opJal;
            isJr <= opcode == cpuPkg::opJr;
            isBranch <= branchOp;
            branchOnZero <= opcode == cpuPkg::opBrz;
            isRelative <= branchOp;
            isHalt <= opcode == cpuPkg::opHalt;
        end
    end

    // Operand fields
    always_ff @(posedge Clock) begin
        if (decodeStrobe) begin
            sourceReg1 <= word.iForm.rs1;
            // Store data register sits in the rd field
            sourceReg2 <= (opcode == cpuPkg::opStore) ? word.iForm.rd : word.rForm.rs2;
            destReg <= word.iForm.rd;
            immediate <= {{(cpuPkg::dataWidth - cpuPkg::immWidth){word.iForm.imm[cpuPkg::immWidth-1]}},
                          word.iForm.imm};
            // Link register overlaps the top of the target, so jal keeps the low 20 bits
            jumpTarget <= {{cpuPkg::regIndexWidth{1'b0}},
                           word.jForm.target[cpuPkg::pcWidth-cpuPkg::regIndexWidth-1:0]};
            aluFunction <= (opcode == cpuPkg::opAluReg) ? word.rForm.funct : cpuPkg::fnAdd;
        end
    end

endmodule

`default_nettype wire

//--- rtl/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter (
    input  logic        Clock,
    input  logic        rstN,
    input  logic [25:0] nextPc,
    input  logic        step,
    input  logic        jump,
    output logic [25:0] currentPc
);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            currentPc <= '0;
        end else if (jump) begin
            currentPc <= nextPc;
        end else if (step) begin
            currentPc <= currentPc + 26'd1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic        Clock,
    input  logic        rstN,
    input  logic [5:0]  sourceReg1,
    input  logic [5:0]  sourceReg2,
    input  logic [5:0]  destReg,
    input  logic [31:0] writeData,
    input  logic        writeEnable,
    output logic [31:0] sourceData1,
    output logic [31:0] sourceData2
);

    logic [cpuPkg::dataWidth-1:0] regs [2**cpuPkg::regIndexWidth];

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < 2**cpuPkg::regIndexWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (destReg != '0)) begin
            regs[destReg] <= writeData;
        end
    end

    // Register 0 is hardwired to zero
    assign sourceData1 = (sourceReg1 == '0) ? '0 : regs[sourceReg1];
    assign sourceData2 = (sourceReg2 == '0) ? '0 : regs[sourceReg2];

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Compile the cpu testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -Mdir obj_dir -f cpu.f \
    && ./obj_dir/VcpuTb | tee /dev/stderr | grep -qx "test passed" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tests/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    localparam int memWords = 256;
    localparam int runTimeout = 6000;

    logic Clock;
    logic rstN;
    logic [31:0] instruction;
    logic instructionLoaded;
    logic [31:0] dataIn;
    logic dataLoaded;
    logic dataStored;
    logic [31:0] instructionAddress;
    logic readInstruction;
    logic [31:0] dataAddress;
    logic [31:0] dataOut;
    logic readData;
    logic writeData;
    logic halted;

    logic [31:0] instrMem [memWords];
    logic [31:0] dataMem [memWords];
    logic [15:0] lfsrState;
    int loadAddress;
    logic [31:0] storeAddrQueue [$];
    logic [31:0] storeDataQueue [$];
    logic [25:0] fetchQueue [$];
    logic [25:0] refHaltPc;

    cpu DUT (
        .Clock(Clock), .rstN(rstN), .instruction(instruction),
        .instructionLoaded(instructionLoaded), .dataIn(dataIn), .dataLoaded(dataLoaded),
        .dataStored(dataStored), .instructionAddress(instructionAddress),
        .readInstruction(readInstruction), .dataAddress(dataAddress), .dataOut(dataOut),
        .readData(readData), .writeData(writeData), .halted(halted)
    );

    bind cpu cpuAssertions protocolChecks (
        .Clock(Clock), .rstN(rstN), .readInstruction(readInstruction),
        .instructionLoaded(instructionLoaded), .readData(readData), .dataLoaded(dataLoaded),
        .writeData(writeData), .dataStored(dataStored), .halted(halted)
    );

    initial begin : clockGen
        Clock = 1'b0;
        forever begin
            #4 Clock = ~Clock;
        end
    end

    task automatic mismatch(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic abortRun(input string what);
        $display("At %0t ns: %s", $time, what);
        $display("test failed");
        $fatal(1);
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [31:0] regWord(input int fn, input int rd, input int rs1,
                                            input int rs2);
        return {cpuPkg::opAluReg, rd[5:0], rs1[5:0], rs2[5:0], fn[5:0], 2'b00};
    endfunction

    function automatic logic [31:0] immWord(input int op, input int rd, input int rs1,
                                            input int imm);
        return {op[5:0], rd[5:0], rs1[5:0], imm[13:0]};
    endfunction

    // Link register sits above a 20-bit target
    function automatic logic [31:0] jalWord(input int rd, input int target);
        return {cpuPkg::opJal, rd[5:0], target[19:0]};
    endfunction

    task automatic emit(input logic [31:0] word);
        instrMem[loadAddress] = word;
        loadAddress++;
    endtask

    task automatic loadProgram();
        logic [5:0] functions [8];
        int loopStart;
        functions = '{cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd, cpuPkg::fnOr,
                      cpuPkg::fnXor, cpuPkg::fnShl, cpuPkg::fnShr, cpuPkg::fnMul};
        // Stray fetches land on a halt carrying its own address
        for (int a = 0; a < memWords; a++) begin
            instrMem[a] = {cpuPkg::opHalt, 26'(a)};
        end
        loadAddress = 0;
        emit(immWord(cpuPkg::opAluImm, 1, 0, 100));
        emit(immWord(cpuPkg::opLoad, 2, 1, 0));
        emit(immWord(cpuPkg::opLoad, 3, 1, 1));
        for (int f = 0; f < 8; f++) begin
            emit(regWord(functions[f], 4, 2, 3));
            emit(immWord(cpuPkg::opStore, 4, 1, 10 + f));
        end
        emit(immWord(cpuPkg::opAluImm, 5, 0, -7));
        emit(regWord(cpuPkg::fnMul, 6, 5, 3));
        emit(immWord(cpuPkg::opStore, 6, 1, 18));
        emit(immWord(cpuPkg::opAluImm, 6, 2, -8192));
        emit(immWord(cpuPkg::opStore, 6, 1, 19));
        // Copy a word twice and read one copy back through a negative offset
        emit(immWord(cpuPkg::opLoad, 7, 1, 2));
        emit(immWord(cpuPkg::opStore, 7, 1, 30));
        emit(immWord(cpuPkg::opStore, 7, 1, -60));
        emit(immWord(cpuPkg::opLoad, 8, 1, -60));
        emit(immWord(cpuPkg::opStore, 8, 1, 31));
        // Call the routine at 200, then store the link value
        emit(jalWord(20, 200));
        emit(immWord(cpuPkg::opStore, 20, 1, 40));
        // r9 is 5 after the call
        emit(immWord(cpuPkg::opBrz, 0, 0, 2));
        emit(immWord(cpuPkg::opStore, 2, 1, 41));
        emit(immWord(cpuPkg::opBrnz, 0, 0, 2));
        emit(immWord(cpuPkg::opStore, 3, 1, 42));
        emit(immWord(cpuPkg::opBrnz, 0, 9, 2));
        emit(immWord(cpuPkg::opStore, 2, 1, 43));
        emit(immWord(cpuPkg::opBrz, 0, 9, 2));
        emit(immWord(cpuPkg::opStore, 3, 1, 44));
        // Count down with a backward branch
        emit(immWord(cpuPkg::opAluImm, 10, 0, 3));
        emit(immWord(cpuPkg::opAluImm, 11, 0, 1));
        loopStart = loadAddress;
        emit(regWord(cpuPkg::fnSub, 10, 10, 11));
        emit(immWord(cpuPkg::opStore, 10, 1, 45));
        emit(immWord(cpuPkg::opBrnz, 0, 10, loopStart - loadAddress));
        emit(immWord(cpuPkg::opAluImm, 0, 0, 77));
        emit(regWord(cpuPkg::fnOr, 0, 2, 3));
        emit(immWord(cpuPkg::opStore, 0, 1, 46));
        emit(immWord(cpuPkg::opHalt, 0, 0, 0));
        loadAddress = 200;
        emit(immWord(cpuPkg::opAluImm, 9, 0, 5));
        emit(immWord(cpuPkg::opStore, 9, 1, 47));
        emit(immWord(cpuPkg::opJr, 0, 20, 0));
    endtask

    function automatic logic [31:0] aluRef(input logic [5:0] fn, input logic [31:0] a,
                                           input logic [31:0] b);
        case (fn)
            cpuPkg::fnAdd: return a + b;
            cpuPkg::fnSub: return a - b;
            cpuPkg::fnAnd: return a & b;
            cpuPkg::fnOr:  return a | b;
            cpuPkg::fnXor: return a ^ b;
            cpuPkg::fnShl: return a << b[4:0];
            cpuPkg::fnShr: return a >> b[4:0];
            cpuPkg::fnMul: return a * b;
            default:       return '0;
        endcase
    endfunction

    // Instruction-set model on its own registers and memory copy
    function automatic void refRun();
        logic [31:0] regs [64];
        logic [31:0] mem [memWords];
        cpuPkg::instructionWord word;
        logic [25:0] pc;
        logic [25:0] nextPc;
        logic [31:0] src1;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] value;
        logic hasResult;
        logic running;
        int steps;
        for (int r = 0; r < 64; r++) begin
            regs[r] = '0;
        end
        for (int a = 0; a < memWords; a++) begin
            mem[a] = dataMem[a];
        end
        pc = '0;
        refHaltPc = '1;
        running = 1'b1;
        steps = 0;
        while (running && steps < 1000) begin
            word = instrMem[pc[7:0]];
            fetchQueue.push_back(pc);
            src1 = regs[word.iForm.rs1];
            imm = {{18{word.iForm.imm[13]}}, word.iForm.imm};
            addr = src1 + imm;
            nextPc = pc + 26'd1;
            hasResult = 1'b0;
            value = '0;
            case (word.rForm.opcode)
                cpuPkg::opAluReg: begin
                    hasResult = 1'b1;
                    value = aluRef(word.rForm.funct, src1, regs[word.rForm.rs2]);
                end
                cpuPkg::opAluImm: begin
                    hasResult = 1'b1;
                    value = addr;
                end
                cpuPkg::opLoad: begin
                    hasResult = 1'b1;
                    value = mem[addr[7:0]];
                end
                cpuPkg::opStore: begin
                    mem[addr[7:0]] = regs[word.iForm.rd];
                    storeAddrQueue.push_back(addr);
                    storeDataQueue.push_back(regs[word.iForm.rd]);
                end
                cpuPkg::opJal: begin
                    hasResult = 1'b1;
                    value = {6'b0, pc + 26'd1};
                    nextPc = {6'b0, word.jForm.target[19:0]};
                end
                cpuPkg::opJr: nextPc = src1[25:0];
                cpuPkg::opBrz: begin
                    if (src1 == '0) begin
                        nextPc = pc + imm[25:0];
                    end
                end
                cpuPkg::opBrnz: begin
                    if (src1 != '0) begin
                        nextPc = pc + imm[25:0];
                    end
                end
                cpuPkg::opHalt: begin
                    running = 1'b0;
                    refHaltPc = pc;
                end
                default: running = 1'b0;
            endcase
            if (hasResult && word.iForm.rd != '0) begin
                regs[word.iForm.rd] = value;
            end
            pc = nextPc;
            steps++;
        end
    endfunction

    initial begin : instructionMemory
        int latency;
        logic [25:0] expectedFetch;
        instruction = '0;
        instructionLoaded = 1'b0;
        forever begin
            @(negedge Clock);
            if (rstN && readInstruction && !instructionLoaded) begin
                assert (fetchQueue.size() > 0) else abortRun("fetch past the expected halt");
                expectedFetch = fetchQueue.pop_front();
                assert (instructionAddress == {6'b0, expectedFetch})
                    else mismatch("instructionAddress", {6'b0, expectedFetch},
                                  instructionAddress);
                latency = int'(randomBits(3));
                repeat (latency) @(negedge Clock);
                instruction = instrMem[instructionAddress[7:0]];
                instructionLoaded = 1'b1;
                @(negedge Clock);
                instructionLoaded = 1'b0;
            end
        end
    end

    initial begin : dataMemory
        int latency;
        dataIn = '0;
        dataLoaded = 1'b0;
        dataStored = 1'b0;
        forever begin
            @(negedge Clock);
            if (rstN && (readData || writeData)) begin
                latency = int'(randomBits(3));
                repeat (latency) @(negedge Clock);
                if (readData) begin
                    dataIn = dataMem[dataAddress[7:0]];
                    dataLoaded = 1'b1;
                end else begin
                    dataMem[dataAddress[7:0]] = dataOut;
                    dataStored = 1'b1;
                end
                @(negedge Clock);
                dataLoaded = 1'b0;
                dataStored = 1'b0;
            end
        end
    end

    // Each new store request against the next expected store
    initial begin : storeChecker
        logic lastWrite;
        logic [31:0] expectedAddress;
        logic [31:0] expectedData;
        lastWrite = 1'b0;
        forever begin
            @(negedge Clock);
            if (rstN && writeData && !lastWrite) begin
                assert (storeAddrQueue.size() > 0) else abortRun("store beyond the expected list");
                expectedAddress = storeAddrQueue.pop_front();
                expectedData = storeDataQueue.pop_front();
                assert (dataAddress == expectedAddress)
                    else mismatch("dataAddress", expectedAddress, dataAddress);
                assert (dataOut == expectedData) else mismatch("dataOut", expectedData, dataOut);
            end
            lastWrite = writeData;
        end
    end

    initial begin : mainSequence
        int cycles;
        rstN = 1'b0;
        lfsrState = 16'd46202;
        loadProgram();
        for (int a = 0; a < memWords; a++) begin
            dataMem[a] = randomBits(32);
        end
        refRun();
        repeat (16) @(negedge Clock);
        rstN <= 1'b1;
        cycles = 0;
        while (!halted && cycles < runTimeout) begin
            @(negedge Clock);
            cycles++;
        end
        assert (halted) else abortRun("timed out waiting for halted");
        assert (instructionAddress == {6'b0, refHaltPc})
            else mismatch("instructionAddress", {6'b0, refHaltPc}, instructionAddress);
        assert (storeAddrQueue.size() == 0) else abortRun("expected stores never issued");
        assert (fetchQueue.size() == 0) else abortRun("fetch sequence ended early");
        // Quiet bus after halt
        repeat (100) begin
            @(negedge Clock);
            assert (!readInstruction && !readData && !writeData)
                else abortRun("request raised after halt");
            assert (halted) else abortRun("halted fell after halt");
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/cpu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpuAssertions (
    input logic Clock,
    input logic rstN,
    input logic readInstruction,
    input logic instructionLoaded,
    input logic readData,
    input logic dataLoaded,
    input logic writeData,
    input logic dataStored,
    input logic halted
);

    // Load and store requests are exclusive
    dataRequestsExclusive: assert property (@(posedge Clock) disable iff (!rstN)
        !(readData && writeData))
        else $error("readData and writeData are high together");

    // Requests held until their completion pulse
    fetchHeld: assert property (@(posedge Clock) disable iff (!rstN)
        readInstruction && !instructionLoaded |=> readInstruction)
        else $error("readInstruction dropped before instructionLoaded");

    loadHeld: assert property (@(posedge Clock) disable iff (!rstN)
        readData && !dataLoaded |=> readData)
        else $error("readData dropped before dataLoaded");

    storeHeld: assert property (@(posedge Clock) disable iff (!rstN)
        writeData && !dataStored |=> writeData)
        else $error("writeData dropped before dataStored");

    haltedSticky: assert property (@(posedge Clock) disable iff (!rstN)
        halted |=> halted)
        else $error("halted fell without a reset");

endmodule

`default_nettype wire
